/* sim.f */
dcache_pkg.sv
dcache_tags.sv
dcache_data.sv
dcache_sb_entry.sv
dcache_store_buffer.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_tags.sv
  - dcache_data.sv
  - dcache_sb_entry.sv
  - dcache_store_buffer.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache_mem.sv
      - tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_LINES  = 8;
    localparam int SB_DEPTH   = 4;
    localparam int MEM_LINES  = 64;
    localparam int CLK_PERIOD = 10;
    localparam int ROW_CYCLES = 40; // Watchdog budget per table row

    typedef struct packed {
        logic                    settle;   // Let the store buffer empty before the row
        logic                    fast;     // Done expected in the first cycle
        logic                    is_store;
        dcache_pkg::memop_type_e size;
        logic [31:0]             addr;
        logic [31:0]             wdata;
        logic [31:0]             exp;      // Expected load data
    } row_t;

    logic                                 clk;
    logic                                 rsn;
    dcache_pkg::core_req_t                core_req;
    logic                                 done;
    logic [dcache_pkg::WORD_SIZE-1:0]     rdata;
    dcache_pkg::mem_req_t                 mem_req;
    logic                                 mem_rvalid;
    dcache_pkg::cache_line_u              mem_line;

    row_t        table_q [$];
    logic        table_ready;
    logic [31:0] shadow [MEM_LINES * dcache_pkg::LINE_WORDS]; // Program order view

    dcache_top #(.NUM_LINES(NUM_LINES), .SB_DEPTH(SB_DEPTH)) dcache_top_i (
        .clk_i        (clk),
        .rsn_i        (rsn),
        .core_req_i   (core_req),
        .done_o       (done),
        .rdata_o      (rdata),
        .mem_req_o    (mem_req),
        .mem_rvalid_i (mem_rvalid),
        .mem_line_i   (mem_line)
    );

    tb_dcache_mem #(.MEM_LINES(MEM_LINES)) mem_i (
        .clk_i        (clk),
        .rsn_i        (rsn),
        .mem_req_i    (mem_req),
        .mem_rvalid_o (mem_rvalid),
        .mem_line_o   (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] put_byte(input logic [31:0] word, input logic [1:0] lane,
                                             input logic [7:0] value);
        logic [31:0] res;
        res = word;
        res[lane*8 +: 8] = value;
        return res;
    endfunction

    function automatic logic [31:0] lane_byte(input logic [31:0] word, input logic [1:0] lane);
        return {24'h0, word[lane*8 +: 8]}; // Zero extended
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Failure and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [dcache_pkg::WORD_SIZE-1:0] got,
                              input logic [dcache_pkg::WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::cache_line_u got,
                              input dcache_pkg::cache_line_u exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operation table
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_row(input logic settle, input logic fast,
                            input dcache_pkg::memop_type_e size,
                            input logic [31:0] addr, input logic [31:0] exp);
        table_q.push_back('{settle, fast, 1'b0, size, addr, 32'h0, exp});
    endtask

    task automatic store_row(input logic fast, input dcache_pkg::memop_type_e size,
                             input logic [31:0] addr, input logic [31:0] wdata);
        table_q.push_back('{1'b0, fast, 1'b1, size, addr, wdata, 32'h0});
    endtask

    task automatic fill_table();
        // Cold misses, hits and byte loads
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h040, init_word(32'h040));
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h040, init_word(32'h040));
        load_row(1'b0, 1'b1, dcache_pkg::MEM_BYTE, 32'h044,
                 lane_byte(init_word(32'h044), 2'd0));
        load_row(1'b0, 1'b1, dcache_pkg::MEM_BYTE, 32'h046,
                 lane_byte(init_word(32'h046), 2'd2));
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h0C8, init_word(32'h0C8)); // Evicts 0x040
        // Store then load from the buffer and then from the cache
        store_row(1'b1, dcache_pkg::MEM_WORD, 32'h050, 32'h1234_5678);
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h050, 32'h1234_5678);
        store_row(1'b1, dcache_pkg::MEM_BYTE, 32'h061, 32'h0000_00C3);
        load_row(1'b0, 1'b1, dcache_pkg::MEM_BYTE, 32'h061, 32'h0000_00C3);
        load_row(1'b1, 1'b1, dcache_pkg::MEM_WORD, 32'h050, 32'h1234_5678);
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h060,
                 put_byte(init_word(32'h060), 2'd1, 8'hC3));
        // Byte store merged into a word load
        store_row(1'b1, dcache_pkg::MEM_BYTE, 32'h042, 32'h0000_0077);
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h040,
                 put_byte(init_word(32'h040), 2'd2, 8'h77));
        // More stores than buffer slots
        store_row(1'b1, dcache_pkg::MEM_WORD, 32'h100, 32'h1111_0001);
        store_row(1'b1, dcache_pkg::MEM_WORD, 32'h104, 32'h2222_0002);
        store_row(1'b1, dcache_pkg::MEM_WORD, 32'h100, 32'h3333_0003);
        store_row(1'b1, dcache_pkg::MEM_BYTE, 32'h108, 32'h0000_00EE);
        store_row(1'b0, dcache_pkg::MEM_WORD, 32'h180, 32'h4444_0004);
        store_row(1'b0, dcache_pkg::MEM_WORD, 32'h104, 32'h5555_0005);
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h100, 32'h3333_0003);
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h104, 32'h5555_0005);
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h108,
                 put_byte(init_word(32'h108), 2'd0, 8'hEE));
        load_row(1'b0, 1'b1, dcache_pkg::MEM_WORD, 32'h180, 32'h4444_0004);
        // Dirty victims of one index go back to memory
        load_row(1'b1, 1'b0, dcache_pkg::MEM_WORD, 32'h200, init_word(32'h200));
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h280, init_word(32'h280));
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h104, 32'h5555_0005);
        load_row(1'b0, 1'b0, dcache_pkg::MEM_WORD, 32'h180, 32'h4444_0004);
        // Sweep every index so that no dirty line stays behind
        for (int i = 0; i < NUM_LINES; i++) begin
            load_row(i == 0, 1'b0, dcache_pkg::MEM_WORD, 32'h300 + 32'(i * 16),
                     init_word(32'h300 + 32'(i * 16)));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Row sequencing
    ////////////////////////////////////////////////////////////////////////////

    task automatic drain_buffer();
        @(posedge clk);
        core_req.valid <= 1'b0;   // Core goes quiet so the controller drains
        @(negedge clk);
        while (!dcache_top_i.sb_empty) @(negedge clk);
    endtask

    task automatic run_row(input row_t row, input int n);
        int widx;
        widx = int'(row.addr >> 2);
        if (row.settle) drain_buffer();
        @(posedge clk);
        core_req <= '{valid: 1'b1, is_store: row.is_store, size: row.size,
                      addr: row.addr, wdata: row.wdata};
        @(negedge clk);
        // Hits, forwards and stores with room finish in the cycle they are presented
        check_bit($sformatf("done_o in first cycle (row %0d)", n), done, row.fast);
        while (!done) @(negedge clk);   // Request held until done
        if (row.is_store) begin
            if (row.size == dcache_pkg::MEM_WORD) shadow[widx] = row.wdata;
            else shadow[widx] = put_byte(shadow[widx], row.addr[1:0], row.wdata[7:0]);
        end else begin
            check_word($sformatf("rdata_o (row %0d)", n), rdata, row.exp);
        end
    endtask

    initial begin
        table_ready = 1'b0;
        wait (table_ready);
        #(CLK_PERIOD * (table_q.size() * ROW_CYCLES + 20));
        abort_run("Timeout, the cache stopped answering requests");
    end

    initial begin
        dcache_pkg::cache_line_u exp_line;
        rsn      = 1'b0;
        core_req = '0;
        for (int w = 0; w < MEM_LINES * dcache_pkg::LINE_WORDS; w++) begin
            shadow[w] = init_word(32'(w * 4));
        end
        fill_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rsn <= 1'b1;

        foreach (table_q[i]) begin
            run_row(table_q[i], i);
        end

        // Whole memory against the shadow copy
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
                exp_line.words[w] = shadow[l * dcache_pkg::LINE_WORDS + w];
            end
            check_line($sformatf("memory line %0d", l), mem_i.lines[l], exp_line);
        end

        $display("Everything OK");
        $finish;
    end

endmodule : tb_dcache

/* tb_dcache_mem.sv */
`timescale 1ns/1ps

module tb_dcache_mem #(
    parameter int MEM_LINES = 64
) (
    input  logic                    clk_i,
    input  logic                    rsn_i,

    input  dcache_pkg::mem_req_t    mem_req_i,
    output logic                    mem_rvalid_o,
    output dcache_pkg::cache_line_u mem_line_o
);

    localparam int AW  = $clog2(MEM_LINES);
    localparam int OFF = dcache_pkg::OFFSET_BITS;

    dcache_pkg::cache_line_u lines [MEM_LINES]; // Backing store, one entry per line

    integer        seed = 32'h6613d266;
    logic          busy_q;
    logic [2:0]    wait_q;
    logic [AW-1:0] line_idx;

    assign line_idx = mem_req_i.addr[OFF +: AW];

    // Every word starts as its byte address XOR a marker
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
                lines[l].words[w] = 32'(l * dcache_pkg::LINE_BYTES + w * 4) ^ 32'hA5A5_0000;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request handling, 1 to 4 cycles per transfer
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            busy_q       <= 1'b0;
            wait_q       <= '0;
            mem_rvalid_o <= 1'b0;
            mem_line_o   <= '0;
        end else begin
            mem_rvalid_o <= 1'b0;
            // In the response cycle the old request is still up, skip it
            if (!mem_rvalid_o) begin
                if (!busy_q) begin
                    if (mem_req_i.valid) begin
                        busy_q <= 1'b1;
                        wait_q <= 3'($unsigned($random(seed)) % 4);
                    end
                end else if (wait_q != '0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    busy_q       <= 1'b0;
                    mem_rvalid_o <= 1'b1;
                    if (mem_req_i.we) begin
                        lines[line_idx] <= mem_req_i.line;  // Writeback
                    end else begin
                        mem_line_o <= lines[line_idx];      // Refill data
                    end
                end
            end
        end
    end

endmodule : tb_dcache_mem

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_LINES = 8,
    parameter int SB_DEPTH  = 4
) (
    input  logic                               clk_i,
    input  logic                               rsn_i,

    input  dcache_pkg::core_req_t              core_req_i,
    output logic                               done_o,
    output logic [dcache_pkg::WORD_SIZE-1:0]   rdata_o,

    output dcache_pkg::mem_req_t               mem_req_o,
    input  logic                               mem_rvalid_i,
    input  dcache_pkg::cache_line_u            mem_line_i
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int OFF   = dcache_pkg::OFFSET_BITS;
    localparam int TAG_W = dcache_pkg::WORD_SIZE - IDX_W - OFF;

    dcache_pkg::sb_store_t            acc;       // Access seen by tags and data
    logic [IDX_W-1:0]                 acc_index;
    logic [TAG_W-1:0]                 acc_tag;

    logic                             hit, dirty;
    logic [TAG_W-1:0]                 victim_tag;
    logic [dcache_pkg::WORD_SIZE-1:0] cache_rdata;
    dcache_pkg::cache_line_u          line;

    logic                             fwd_sel, drain_sel;
    logic                             tag_fill, mark_dirty, data_wr, data_fill;

    logic                             sb_push, sb_pop;
    dcache_pkg::sb_store_t            sb_push_store, sb_head;
    logic                             sb_full, sb_empty, sb_fwd_hit, sb_conflict;
    logic [dcache_pkg::WORD_SIZE-1:0] sb_fwd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Address and result muxes
    ////////////////////////////////////////////////////////////////////////////

    assign acc = drain_sel ? sb_head
               : '{size: core_req_i.size, addr: core_req_i.addr, wdata: core_req_i.wdata};

    assign acc_index = acc.addr[OFF+IDX_W-1:OFF];
    assign acc_tag   = acc.addr[dcache_pkg::WORD_SIZE-1:OFF+IDX_W];

    assign rdata_o = fwd_sel ? sb_fwd_data : cache_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    dcache_ctrl #(.NUM_LINES(NUM_LINES)) ctrl_i (
        .clk_i(clk_i), .rsn_i(rsn_i),
        .core_req_i      (core_req_i),
        .acc_addr_i      (acc.addr),
        .hit_i           (hit),
        .dirty_i         (dirty),
        .victim_tag_i    (victim_tag),
        .line_i          (line),
        .sb_full_i       (sb_full),
        .sb_empty_i      (sb_empty),
        .sb_fwd_hit_i    (sb_fwd_hit),
        .sb_conflict_i   (sb_conflict),
        .mem_rvalid_i    (mem_rvalid_i),
        .done_o          (done_o),
        .fwd_sel_o       (fwd_sel),
        .drain_sel_o     (drain_sel),
        .tag_fill_o      (tag_fill),
        .mark_dirty_o    (mark_dirty),
        .data_wr_o       (data_wr),
        .data_fill_o     (data_fill),
        .sb_push_o       (sb_push),
        .sb_push_store_o (sb_push_store),
        .sb_pop_o        (sb_pop),
        .mem_req_o       (mem_req_o)
    );

    dcache_tags #(.NUM_LINES(NUM_LINES)) tags_i (
        .clk_i(clk_i), .rsn_i(rsn_i),
        .index_i      (acc_index),
        .tag_i        (acc_tag),
        .fill_i       (tag_fill),
        .mark_dirty_i (mark_dirty),
        .hit_o        (hit),
        .dirty_o      (dirty),
        .victim_tag_o (victim_tag)
    );

    dcache_data #(.NUM_LINES(NUM_LINES)) data_i (
        .clk_i(clk_i), .rsn_i(rsn_i),
        .index_i     (acc_index),
        .offset_i    (acc.addr[OFF-1:0]),
        .wr_word_i   (data_wr),
        .store_i     (acc),
        .fill_i      (data_fill),
        .fill_line_i (mem_line_i),
        .rdata_o     (cache_rdata),
        .line_o      (line)
    );

    // Probed with the core address, whatever the controller is doing
    dcache_store_buffer #(.SB_DEPTH(SB_DEPTH)) sb_i (
        .clk_i(clk_i), .rsn_i(rsn_i),
        .push_i       (sb_push),
        .push_store_i (sb_push_store),
        .pop_i        (sb_pop),
        .probe_addr_i (core_req_i.addr),
        .probe_size_i (core_req_i.size),
        .full_o       (sb_full),
        .empty_o      (sb_empty),
        .head_o       (sb_head),
        .fwd_hit_o    (sb_fwd_hit),
        .fwd_data_o   (sb_fwd_data),
        .conflict_o   (sb_conflict)
    );

endmodule : dcache_top

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter  int NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dcache_pkg::WORD_SIZE - IDX_W - dcache_pkg::OFFSET_BITS
) (
    input  logic                               clk_i,
    input  logic                               rsn_i,

    input  dcache_pkg::core_req_t              core_req_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0]   acc_addr_i,   // Address on the tags and data
    input  logic                               hit_i,
    input  logic                               dirty_i,
    input  logic [TAG_W-1:0]                   victim_tag_i,
    input  dcache_pkg::cache_line_u            line_i,
    input  logic                               sb_full_i,
    input  logic                               sb_empty_i,
    input  logic                               sb_fwd_hit_i,
    input  logic                               sb_conflict_i,
    input  logic                               mem_rvalid_i,

    output logic                               done_o,
    output logic                               fwd_sel_o,    // Load data from the buffer
    output logic                               drain_sel_o,  // Address from the buffer head
    output logic                               tag_fill_o,
    output logic                               mark_dirty_o,
    output logic                               data_wr_o,
    output logic                               data_fill_o,
    output logic                               sb_push_o,
    output dcache_pkg::sb_store_t              sb_push_store_o,
    output logic                               sb_pop_o,
    output dcache_pkg::mem_req_t               mem_req_o
);

    localparam int OFF = dcache_pkg::OFFSET_BITS;

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        WRITEBACK,
        REFILL
    } state_e;

    state_e state_q, state_d;
    logic   drain_q, drain_d; // Miss sequence belongs to a drained store

    logic   is_load;
    logic   is_store;
    logic   load_stall;
    logic   store_stall;
    logic   may_drain;

    assign is_load     = core_req_i.valid && !core_req_i.is_store;
    assign is_store    = core_req_i.valid && core_req_i.is_store;
    assign load_stall  = is_load && sb_conflict_i;
    assign store_stall = is_store && sb_full_i;
    // Drain only when the core is absent or waiting on the buffer
    assign may_drain   = !sb_empty_i && (!core_req_i.valid || load_stall || store_stall);

    assign drain_sel_o = (state_q == DRAIN)
                         || ((state_q inside {WRITEBACK, REFILL}) && drain_q);

    assign sb_push_store_o = '{size:  core_req_i.size,
                               addr:  core_req_i.addr,
                               wdata: core_req_i.wdata};

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            state_q <= IDLE;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_d;
            drain_q <= drain_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state and per cycle strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        drain_d      = drain_q;
        done_o       = 1'b0;
        fwd_sel_o    = 1'b0;
        tag_fill_o   = 1'b0;
        mark_dirty_o = 1'b0;
        data_wr_o    = 1'b0;
        data_fill_o  = 1'b0;
        sb_push_o    = 1'b0;
        sb_pop_o     = 1'b0;

        case (state_q)
            IDLE: begin
                if (may_drain) begin
                    state_d = DRAIN;
                end else if (is_store) begin
                    sb_push_o = 1'b1; // Buffer has room here
                    done_o    = 1'b1;
                end else if (is_load) begin
                    if (sb_fwd_hit_i) begin
                        fwd_sel_o = 1'b1;
                        done_o    = 1'b1;
                    end else if (hit_i) begin
                        done_o = 1'b1;
                    end else begin
                        drain_d = 1'b0;
                        state_d = dirty_i ? WRITEBACK : REFILL;
                    end
                end
            end

            DRAIN: begin
                if (!may_drain) begin
                    state_d = IDLE;
                end else if (hit_i) begin
                    data_wr_o    = 1'b1;
                    mark_dirty_o = 1'b1;
                    sb_pop_o     = 1'b1;
                end else begin
                    drain_d = 1'b1;
                    state_d = dirty_i ? WRITEBACK : REFILL;
                end
            end

            WRITEBACK: begin
                if (mem_rvalid_i) state_d = REFILL;
            end

            REFILL: begin
                if (mem_rvalid_i) begin
                    tag_fill_o  = 1'b1;
                    data_fill_o = 1'b1;
                    state_d     = drain_q ? DRAIN : IDLE; // Retry the lookup, now a hit
                end
            end

            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_req_o.valid = state_q inside {WRITEBACK, REFILL};
        mem_req_o.we    = (state_q == WRITEBACK);
        mem_req_o.line  = line_i;
        if (state_q == WRITEBACK) begin
            mem_req_o.addr = {victim_tag_i, acc_addr_i[OFF+IDX_W-1:OFF], {OFF{1'b0}}};
        end else begin
            mem_req_o.addr = {acc_addr_i[dcache_pkg::WORD_SIZE-1:OFF], {OFF{1'b0}}};
        end
    end

endmodule : dcache_ctrl

/* dcache_store_buffer.sv */
`timescale 1ns/1ps

module dcache_store_buffer #(
    parameter  int SB_DEPTH = 4,
    localparam int PTR_W    = $clog2(SB_DEPTH)
) (
    input  logic                               clk_i,
    input  logic                               rsn_i,

    input  logic                               push_i,
    input  dcache_pkg::sb_store_t              push_store_i,
    input  logic                               pop_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0]   probe_addr_i,
    input  dcache_pkg::memop_type_e            probe_size_i,

    output logic                               full_o,
    output logic                               empty_o,
    output dcache_pkg::sb_store_t              head_o,
    output logic                               fwd_hit_o,
    output logic [dcache_pkg::WORD_SIZE-1:0]   fwd_data_o,
    output logic                               conflict_o
);

    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [SB_DEPTH-1:0]   valid;
    logic [SB_DEPTH-1:0]   match;
    logic [SB_DEPTH-1:0]   exact;
    dcache_pkg::sb_store_t stores [SB_DEPTH];

    logic                  young_found;
    logic                  young_exact;
    dcache_pkg::sb_store_t young_store;

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_i) tail_q <= tail_q + 1'b1; // Wraps, depth is a power of two
            if (pop_i)  head_q <= head_q + 1'b1;
        end
    end

    for (genvar i = 0; i < SB_DEPTH; i++) begin : g_entry
        dcache_sb_entry entry_i (
            .clk_i        (clk_i),
            .rsn_i        (rsn_i),
            .load_en_i    (push_i && (tail_q == PTR_W'(i))),
            .load_i       (push_store_i),
            .clear_i      (pop_i && (head_q == PTR_W'(i))),
            .probe_addr_i (probe_addr_i),
            .probe_size_i (probe_size_i),
            .valid_o      (valid[i]),
            .store_o      (stores[i]),
            .match_o      (match[i]),
            .exact_o      (exact[i])
        );
    end

    assign full_o  = &valid;
    assign empty_o = ~|valid;
    assign head_o  = stores[head_q];

    // Walk from oldest to youngest, the last match wins
    always_comb begin
        logic [PTR_W-1:0] idx;
        young_found = 1'b0;
        young_exact = 1'b0;
        young_store = '0;
        for (int k = 0; k < SB_DEPTH; k++) begin
            idx = head_q + PTR_W'(k);
            if (match[idx]) begin
                young_found = 1'b1;
                young_exact = exact[idx];
                young_store = stores[idx];
            end
        end
    end

    assign fwd_hit_o  = young_found && young_exact;
    assign conflict_o = young_found && !young_exact; // Needs a drain before the load
    assign fwd_data_o = (young_store.size == dcache_pkg::MEM_WORD) ? young_store.wdata
                      : {{(dcache_pkg::WORD_SIZE-8){1'b0}}, young_store.wdata[7:0]};

endmodule : dcache_store_buffer

/* dcache_sb_entry.sv */
`timescale 1ns/1ps

module dcache_sb_entry (
    input  logic                               clk_i,
    input  logic                               rsn_i,

    input  logic                               load_en_i,
    input  dcache_pkg::sb_store_t              load_i,
    input  logic                               clear_i,
    input  logic [dcache_pkg::WORD_SIZE-1:0]   probe_addr_i,
    input  dcache_pkg::memop_type_e            probe_size_i,

    output logic                               valid_o,
    output dcache_pkg::sb_store_t              store_o,
    output logic                               match_o, // Same word
    output logic                               exact_o  // Same word, size and byte
);

    logic                  valid_q;
    dcache_pkg::sb_store_t store_q;

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            valid_q <= 1'b0;
        end else if (load_en_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_en_i) store_q <= load_i;
    end

    assign valid_o = valid_q;
    assign store_o = store_q;

    // Bits 1:0 select the byte inside the word
    assign match_o = valid_q
                     && (store_q.addr[dcache_pkg::WORD_SIZE-1:2] ==
                         probe_addr_i[dcache_pkg::WORD_SIZE-1:2]);
    assign exact_o = match_o && (store_q.size == probe_size_i)
                     && (store_q.addr[1:0] == probe_addr_i[1:0]);

endmodule : dcache_sb_entry

/* dcache_data.sv */
`timescale 1ns/1ps

module dcache_data #(
    parameter  int NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES)
) (
    input  logic                                  clk_i,
    input  logic                                  rsn_i,

    input  logic [IDX_W-1:0]                      index_i,
    input  logic [dcache_pkg::OFFSET_BITS-1:0]    offset_i,
    input  logic                                  wr_word_i,
    input  dcache_pkg::sb_store_t                 store_i,   // Size and data of the access
    input  logic                                  fill_i,
    input  dcache_pkg::cache_line_u               fill_line_i,

    output logic [dcache_pkg::WORD_SIZE-1:0]      rdata_o,
    output dcache_pkg::cache_line_u               line_o
);

    localparam int WSEL_HI = dcache_pkg::OFFSET_BITS - 1;

    dcache_pkg::cache_line_u lines_q [NUM_LINES];

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                lines_q[i] <= '0;
            end
        end else if (fill_i) begin
            lines_q[index_i] <= fill_line_i;
        end else if (wr_word_i) begin
            if (store_i.size == dcache_pkg::MEM_WORD) begin
                lines_q[index_i].words[offset_i[WSEL_HI:2]] <= store_i.wdata;
            end else begin
                lines_q[index_i].bytes[offset_i] <= store_i.wdata[7:0];
            end
        end
    end

    assign line_o = lines_q[index_i]; // Also the writeback payload

    // Load result, bytes come back zero extended
    always_comb begin
        if (store_i.size == dcache_pkg::MEM_WORD) begin
            rdata_o = line_o.words[offset_i[WSEL_HI:2]];
        end else begin
            rdata_o = {{(dcache_pkg::WORD_SIZE-8){1'b0}}, line_o.bytes[offset_i]};
        end
    end

endmodule : dcache_data

/* dcache_tags.sv */
`timescale 1ns/1ps

module dcache_tags #(
    parameter  int NUM_LINES = 8,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dcache_pkg::WORD_SIZE - IDX_W - dcache_pkg::OFFSET_BITS
) (
    input  logic             clk_i,
    input  logic             rsn_i,

    input  logic [IDX_W-1:0] index_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic             fill_i,       // Refill done, line now clean
    input  logic             mark_dirty_i, // A store was written into the line

    output logic             hit_o,
    output logic             dirty_o,
    output logic [TAG_W-1:0] victim_tag_o
);

    logic [TAG_W-1:0]     tags_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= 1'b0;
        end else if (mark_dirty_i) begin
            dirty_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) tags_q[index_i] <= tag_i;
    end

    assign hit_o        = valid_q[index_i] && (tags_q[index_i] == tag_i);
    assign dirty_o      = valid_q[index_i] && dirty_q[index_i]; // Victim must go back first
    assign victim_tag_o = tags_q[index_i];

endmodule : dcache_tags

/* dcache_pkg.sv */
package dcache_pkg;

    localparam int WORD_SIZE   = 32;
    localparam int LINE_BYTES  = 16;
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES); // Byte offset inside a line

    typedef enum logic {
        MEM_BYTE,
        MEM_WORD
    } memop_type_e;

    // One line, seen either byte by byte or word by word
    typedef union packed {
        logic [LINE_BYTES-1:0][7:0]           bytes;
        logic [LINE_WORDS-1:0][WORD_SIZE-1:0] words;
    } cache_line_u;

    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        memop_type_e          size;
        logic [WORD_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] wdata;
    } core_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;   // 1 writeback, 0 refill
        logic [WORD_SIZE-1:0] addr; // Line aligned
        cache_line_u          line;
    } mem_req_t;

    // A committed store waiting in the store buffer
    typedef struct packed {
        memop_type_e          size;
        logic [WORD_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] wdata;
    } sb_store_t;

endpackage : dcache_pkg
